//--- hw/mapper_pkg.sv
`default_nettype none

package mapper_pkg;

	// Bank numbers as they sit in the mapper registers
	typedef logic [4:0] prg_bank_t;
	typedef logic [7:0] chr_bank_t;

	// Pointer written at $E000 that picks which PRG bank $F000 updates
	typedef logic [3:0] prg_sel_t;

	// IRQ counter and reload latch share one width
	typedef logic [15:0] irq_count_t;

	typedef logic [15:0] cpu_addr_t;
	typedef logic [13:0] ppu_addr_t;
	typedef logic [7:0] map_byte_t;

	// One decoded action per m2 cycle, produced by the register decoder
	typedef enum logic [2:0] {
		ACT_NONE,
		ACT_LATCH_NIB,
		ACT_IRQ_CTRL,
		ACT_IRQ_ACK,
		ACT_PRG_SEL,
		ACT_BANK_DATA,
		ACT_SS_WRITE
	} reg_action_t;

	// Side effect of a $F000 write, chosen by cpu_addr[11:10]
	localparam logic [1:0] SUB_PRG_HI = 2'b00;
	localparam logic [1:0] SUB_MIRROR = 2'b10;
	localparam logic [1:0] SUB_CHR = 2'b11;

	// The last 8 KB PRG window is hardwired to the top bank
	localparam prg_bank_t PRG_LAST_BANK = 5'h1F;

	// Counter value on which the timer fires and reloads
	localparam irq_count_t IRQ_LAST = 16'hFFFE;

endpackage

`default_nettype wire

//--- hw/savestate_pkg.sv
`default_nettype none

package savestate_pkg;

	typedef logic [7:0] ss_addr_t;

	// Byte map of the mapper state as seen by the save-state controller
	localparam ss_addr_t SS_CHR_BASE = 8'd0;
	localparam ss_addr_t SS_PRG_BASE = 8'd8;
	localparam ss_addr_t SS_FLAGS = 8'd12;
	localparam ss_addr_t SS_CNT_LO = 8'd13;
	localparam ss_addr_t SS_CNT_HI = 8'd14;
	localparam ss_addr_t SS_LAT_LO = 8'd15;
	localparam ss_addr_t SS_LAT_HI = 8'd16;
	localparam ss_addr_t SS_ID = 8'd127;

	// Lets the controller confirm which mapper produced the state
	localparam logic [7:0] MAPPER_ID = 8'd4;

	// Returned for every address outside the map
	localparam logic [7:0] SS_UNUSED = 8'hFF;

endpackage

`default_nettype wire

//--- hw/map_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

// Decoded register write, valid for the single m2 cycle it is presented in
interface map_wr_if
	import mapper_pkg::*, savestate_pkg::*;
();

	reg_action_t action;
	// cpu_addr[11:10] of a $F000 write
	logic [1:0] sub;
	// Register index, or the latch nibble for ACT_LATCH_NIB
	logic [2:0] idx;
	ss_addr_t ss_addr;
	map_byte_t data;

	modport decoder (
		output action, sub, idx, ss_addr, data
	);

	modport target (
		input action, sub, idx, ss_addr, data
	);

endinterface

`default_nettype wire

//--- hw/map_reg_decode.sv
`timescale 1ns/1ps
`default_nettype none

module map_reg_decode
	import mapper_pkg::*, savestate_pkg::*;
(
	input wire cpu_addr_t cpu_addr,
	input wire map_byte_t cpu_dat,
	input wire logic cpu_rw,
	input wire logic ss_act,
	input wire logic ss_we,
	input wire ss_addr_t ss_addr,
	map_wr_if.decoder wr
);

	always_comb begin
		wr.action = ACT_NONE;
		wr.sub = cpu_addr[11:10];
		wr.idx = cpu_addr[2:0];
		wr.ss_addr = ss_addr;
		// Save-state data also arrives on the CPU data bus
		wr.data = cpu_dat;

		if (ss_act) begin
			// The CPU is frozen while the controller owns the state
			wr.idx = ss_addr[2:0];
			if (ss_we) begin
				wr.action = ACT_SS_WRITE;
			end
		end else if (!cpu_rw) begin
			case (cpu_addr[15:12])
				4'h8, 4'h9, 4'hA, 4'hB: begin
					wr.action = ACT_LATCH_NIB;
					// $8000 holds the low nibble, $B000 the high one
					wr.idx = {1'b0, cpu_addr[13:12]};
				end
				4'hC: wr.action = ACT_IRQ_CTRL;
				4'hD: wr.action = ACT_IRQ_ACK;
				4'hE: wr.action = ACT_PRG_SEL;
				4'hF: wr.action = ACT_BANK_DATA;
				default: wr.action = ACT_NONE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/bank_regs.sv
`timescale 1ns/1ps
`default_nettype none

module bank_regs
	import mapper_pkg::*, savestate_pkg::*;
(
	input wire logic m2,
	input wire logic map_rst,
	map_wr_if.target wr,
	input wire cpu_addr_t cpu_addr,
	input wire logic cpu_ce,
	input wire logic cpu_rw,
	input wire ppu_addr_t ppu_addr,
	input wire logic ppu_oe,
	input wire logic ppu_we,
	input wire logic cfg_chr_ram,
	input wire ss_addr_t ss_addr,
	output logic [17:0] prg_addr,
	output logic [17:0] chr_addr,
	output logic ram_ce,
	output logic ram_we,
	output logic rom_ce,
	output logic prg_oe,
	output logic chr_ce,
	output logic chr_we,
	output logic chr_oe,
	output logic ciram_a10,
	output logic ciram_ce,
	output map_byte_t bank_rdat
);

	prg_bank_t prg_bank [4];
	chr_bank_t chr_bank [8];
	prg_sel_t prg_sel;
	logic mirror;
	prg_bank_t prg_hi;

	always_ff @(posedge m2) begin
		if (map_rst) begin
			for (int i = 0; i < 4; i++) begin
				prg_bank[i] <= '0;
			end
			for (int i = 0; i < 8; i++) begin
				chr_bank[i] <= '0;
			end
			prg_sel <= '0;
			mirror <= 1'b0;
		end else begin
			case (wr.action)
				// The game writes the bank number plus one
				ACT_PRG_SEL: prg_sel <= wr.data[3:0] - 4'd1;
				ACT_BANK_DATA: begin
					if (prg_sel < 4'd3) begin
						prg_bank[prg_sel[1:0]][3:0] <= wr.data[3:0];
					end else if (prg_sel == 4'd3) begin
						prg_bank[3] <= wr.data[4:0];
					end
					case (wr.sub)
						SUB_PRG_HI: begin
							// Bank 3 gets its top bit from the full write above
							if (wr.idx < 3'd3) begin
								prg_bank[wr.idx[1:0]][4] <= wr.data[4];
							end
						end
						SUB_MIRROR: mirror <= wr.data[0];
						SUB_CHR: chr_bank[wr.idx] <= wr.data;
						default: ;
					endcase
				end
				ACT_SS_WRITE: begin
					if (wr.ss_addr inside {[SS_CHR_BASE : SS_PRG_BASE - 8'd1]}) begin
						chr_bank[wr.idx] <= wr.data;
					end else if (wr.ss_addr inside {[SS_PRG_BASE : SS_FLAGS - 8'd1]}) begin
						prg_bank[wr.idx[1:0]] <= wr.data[4:0];
					end else if (wr.ss_addr == SS_FLAGS) begin
						{mirror, prg_sel} <= wr.data[4:0];
					end
				end
				default: ;
			endcase
		end
	end

	// With cpu_ce high the whole CPU range sees bank 3
	always_comb begin
		if (cpu_ce) begin
			prg_hi = prg_bank[3];
		end else if (cpu_addr[14:13] == 2'd3) begin
			prg_hi = PRG_LAST_BANK;
		end else begin
			prg_hi = prg_bank[cpu_addr[14:13]];
		end
	end

	assign prg_addr = {prg_hi, cpu_addr[12:0]};
	assign chr_addr = {chr_bank[ppu_addr[12:10]], ppu_addr[9:0]};

	// Mirror 0 is vertical and 1 is horizontal
	assign ciram_a10 = mirror ? ppu_addr[11] : ppu_addr[10];
	assign ciram_ce = !ppu_addr[13];

	assign ram_ce = (cpu_addr[14:13] == 2'b11) & cpu_ce & m2;
	assign ram_we = !cpu_rw;
	assign rom_ce = !cpu_ce;
	assign prg_oe = cpu_rw;
	assign chr_ce = ciram_ce;
	// Boards with CHR ROM never see a write strobe
	assign chr_we = cfg_chr_ram & !ppu_we & ciram_ce;
	assign chr_oe = !ppu_oe;

	always_comb begin
		if (ss_addr inside {[SS_CHR_BASE : SS_PRG_BASE - 8'd1]}) begin
			bank_rdat = chr_bank[ss_addr[2:0]];
		end else if (ss_addr inside {[SS_PRG_BASE : SS_FLAGS - 8'd1]}) begin
			bank_rdat = {3'b000, prg_bank[ss_addr[1:0]]};
		end else if (ss_addr == SS_FLAGS) begin
			bank_rdat = {3'b000, mirror, prg_sel};
		end else begin
			bank_rdat = '0;
		end
	end

endmodule

`default_nettype wire

//--- hw/irq_timer.sv
`timescale 1ns/1ps
`default_nettype none

module irq_timer
	import mapper_pkg::*, savestate_pkg::*;
(
	input wire logic m2,
	input wire logic map_rst,
	map_wr_if.target wr,
	input wire logic ss_act,
	input wire ss_addr_t ss_addr,
	output logic irq,
	output map_byte_t irq_rdat
);

	irq_count_t irq_count;
	irq_count_t irq_latch;
	logic irq_enable;
	logic irq_flag;

	always_ff @(posedge m2) begin
		if (map_rst) begin
			irq_count <= '0;
			irq_latch <= '0;
			irq_enable <= 1'b0;
			irq_flag <= 1'b0;
		end else begin
			// One tick per CPU cycle, frozen during save-state access
			if (irq_enable && !ss_act) begin
				if (irq_count == IRQ_LAST) begin
					irq_count <= irq_latch;
					irq_enable <= 1'b0;
					irq_flag <= 1'b1;
				end else begin
					irq_count <= irq_count + 16'd1;
				end
			end
			// A register write in the same cycle overrides the tick
			case (wr.action)
				ACT_LATCH_NIB: begin
					irq_flag <= 1'b0;
					irq_latch[{wr.idx[1:0], 2'b00} +: 4] <= wr.data[3:0];
				end
				ACT_IRQ_CTRL: begin
					irq_flag <= 1'b0;
					irq_enable <= (wr.data != 8'd0);
					if (wr.data != 8'd0) begin
						irq_count <= irq_latch;
					end
				end
				ACT_IRQ_ACK: irq_flag <= 1'b0;
				ACT_SS_WRITE: begin
					case (wr.ss_addr)
						SS_FLAGS: {irq_enable, irq_flag} <= wr.data[6:5];
						SS_CNT_LO: irq_count[7:0] <= wr.data;
						SS_CNT_HI: irq_count[15:8] <= wr.data;
						SS_LAT_LO: irq_latch[7:0] <= wr.data;
						SS_LAT_HI: irq_latch[15:8] <= wr.data;
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	assign irq = irq_flag;

	always_comb begin
		case (ss_addr)
			SS_FLAGS: irq_rdat = {1'b0, irq_enable, irq_flag, 5'b00000};
			SS_CNT_LO: irq_rdat = irq_count[7:0];
			SS_CNT_HI: irq_rdat = irq_count[15:8];
			SS_LAT_LO: irq_rdat = irq_latch[7:0];
			SS_LAT_HI: irq_rdat = irq_latch[15:8];
			default: irq_rdat = '0;
		endcase
	end

	// The flag may only come from a timer wrap or from restored state
	a_irq_source: assert property (@(posedge m2) disable iff (map_rst)
		$rose(irq) |-> ($past(irq_count) == IRQ_LAST && $past(irq_enable) && !$past(ss_act))
			|| $past(wr.action) == ACT_SS_WRITE)
	else $error("irq rose without a counter wrap or save-state write");

endmodule

`default_nettype wire

//--- hw/savestate_readback.sv
`timescale 1ns/1ps
`default_nettype none

module savestate_readback
	import mapper_pkg::*, savestate_pkg::*;
(
	input wire ss_addr_t ss_addr,
	input wire map_byte_t bank_rdat,
	input wire map_byte_t irq_rdat,
	output map_byte_t ss_rdat
);

	always_comb begin
		if (ss_addr inside {[SS_CHR_BASE : SS_FLAGS - 8'd1]}) begin
			ss_rdat = bank_rdat;
		end else if (ss_addr == SS_FLAGS) begin
			// Each block drives zeros in the flag bits it does not own
			ss_rdat = bank_rdat | irq_rdat;
		end else if (ss_addr inside {[SS_CNT_LO : SS_LAT_HI]}) begin
			ss_rdat = irq_rdat;
		end else if (ss_addr == SS_ID) begin
			ss_rdat = MAPPER_ID;
		end else begin
			ss_rdat = SS_UNUSED;
		end
	end

endmodule

`default_nettype wire

//--- hw/mapper_056_top.sv
`timescale 1ns/1ps
`default_nettype none

module mapper_056_top
	import mapper_pkg::*, savestate_pkg::*;
(
	input wire logic m2,
	input wire logic map_rst,
	input wire cpu_addr_t cpu_addr,
	input wire map_byte_t cpu_dat,
	input wire logic cpu_rw,
	input wire logic cpu_ce,
	input wire ppu_addr_t ppu_addr,
	input wire logic ppu_oe,
	input wire logic ppu_we,
	input wire logic cfg_chr_ram,
	input wire logic ss_act,
	input wire logic ss_we,
	input wire ss_addr_t ss_addr,
	output logic [17:0] prg_addr,
	output logic [17:0] chr_addr,
	output logic ram_ce,
	output logic ram_we,
	output logic rom_ce,
	output logic prg_oe,
	output logic chr_ce,
	output logic chr_we,
	output logic chr_oe,
	output logic ciram_a10,
	output logic ciram_ce,
	output logic irq,
	output map_byte_t ss_rdat
);

	map_byte_t bank_rdat;
	map_byte_t irq_rdat;

	map_wr_if wr_bus ();

	map_reg_decode map_reg_decode_inst (
		.cpu_addr (cpu_addr),
		.cpu_dat (cpu_dat),
		.cpu_rw (cpu_rw),
		.ss_act (ss_act),
		.ss_we (ss_we),
		.ss_addr (ss_addr),
		.wr (wr_bus.decoder)
	);

	bank_regs bank_regs_inst (
		.m2 (m2),
		.map_rst (map_rst),
		.wr (wr_bus.target),
		.cpu_addr (cpu_addr),
		.cpu_ce (cpu_ce),
		.cpu_rw (cpu_rw),
		.ppu_addr (ppu_addr),
		.ppu_oe (ppu_oe),
		.ppu_we (ppu_we),
		.cfg_chr_ram (cfg_chr_ram),
		.ss_addr (ss_addr),
		.prg_addr (prg_addr),
		.chr_addr (chr_addr),
		.ram_ce (ram_ce),
		.ram_we (ram_we),
		.rom_ce (rom_ce),
		.prg_oe (prg_oe),
		.chr_ce (chr_ce),
		.chr_we (chr_we),
		.chr_oe (chr_oe),
		.ciram_a10 (ciram_a10),
		.ciram_ce (ciram_ce),
		.bank_rdat (bank_rdat)
	);

	irq_timer irq_timer_inst (
		.m2 (m2),
		.map_rst (map_rst),
		.wr (wr_bus.target),
		.ss_act (ss_act),
		.ss_addr (ss_addr),
		.irq (irq),
		.irq_rdat (irq_rdat)
	);

	savestate_readback savestate_readback_inst (
		.ss_addr (ss_addr),
		.bank_rdat (bank_rdat),
		.irq_rdat (irq_rdat),
		.ss_rdat (ss_rdat)
	);

endmodule

`default_nettype wire

//--- testbench/tb_mapper_056.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mapper_056;

	localparam int CLK_PERIOD = 40;

	// Cycle budget of each test, with room to spare
	localparam int RESET_CYCLES = 10;
	localparam int PRG_CYCLES = 60;
	localparam int CHR_CYCLES = 60;
	localparam int IRQ_CYCLES = 80;
	localparam int SS_CYCLES = 120;
	localparam int CE_CYCLES = 40;
	localparam int TIMEOUT_NS = 2 * CLK_PERIOD *
		(RESET_CYCLES + PRG_CYCLES + CHR_CYCLES + IRQ_CYCLES + SS_CYCLES + CE_CYCLES);

	logic m2;
	logic map_rst;
	logic [15:0] cpu_addr;
	logic [7:0] cpu_dat;
	logic cpu_rw;
	logic cpu_ce;
	logic [13:0] ppu_addr;
	logic ppu_oe;
	logic ppu_we;
	logic cfg_chr_ram;
	logic ss_act;
	logic ss_we;
	logic [7:0] ss_addr;
	logic [17:0] prg_addr;
	logic [17:0] chr_addr;
	logic ram_ce;
	logic ram_we;
	logic rom_ce;
	logic prg_oe;
	logic chr_ce;
	logic chr_we;
	logic chr_oe;
	logic ciram_a10;
	logic ciram_ce;
	logic irq;
	logic [7:0] ss_rdat;

	// Expected mapper registers, updated as the tests write them
	logic [4:0] exp_prg [4];
	logic [7:0] exp_chr [8];
	logic [3:0] exp_sel;
	logic exp_mirror;

	int error_count;
	int check_count;
	int seed;

	mapper_056_top mapper_056_top_inst (
		.m2 (m2),
		.map_rst (map_rst),
		.cpu_addr (cpu_addr),
		.cpu_dat (cpu_dat),
		.cpu_rw (cpu_rw),
		.cpu_ce (cpu_ce),
		.ppu_addr (ppu_addr),
		.ppu_oe (ppu_oe),
		.ppu_we (ppu_we),
		.cfg_chr_ram (cfg_chr_ram),
		.ss_act (ss_act),
		.ss_we (ss_we),
		.ss_addr (ss_addr),
		.prg_addr (prg_addr),
		.chr_addr (chr_addr),
		.ram_ce (ram_ce),
		.ram_we (ram_we),
		.rom_ce (rom_ce),
		.prg_oe (prg_oe),
		.chr_ce (chr_ce),
		.chr_we (chr_we),
		.chr_oe (chr_oe),
		.ciram_a10 (ciram_a10),
		.ciram_ce (ciram_ce),
		.irq (irq),
		.ss_rdat (ss_rdat)
	);

	always #(CLK_PERIOD / 2) m2 = ~m2;

	task automatic expect_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		assert (actual === expected)
		else begin
			error_count++;
			$display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// One CPU write cycle, driven from one falling edge to the next
	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(negedge m2);
		cpu_addr = addr;
		cpu_dat = data;
		cpu_rw = 1'b0;
		@(negedge m2);
		cpu_rw = 1'b1;
	endtask

	task automatic ss_write(input logic [7:0] addr, input logic [7:0] data);
		@(negedge m2);
		ss_addr = addr;
		cpu_dat = data;
		ss_we = 1'b1;
		@(negedge m2);
		ss_we = 1'b0;
	endtask

	task automatic ss_read(input logic [7:0] addr, output logic [7:0] data);
		@(negedge m2);
		ss_addr = addr;
		#1;
		data = ss_rdat;
	endtask

	// $E000 stores the pointer, $F000 writes the pointed bank plus one side effect
	task automatic write_and_track(input logic [15:0] addr, input logic [7:0] data);
		cpu_write(addr, data);
		if (addr[15:12] == 4'hE) begin
			exp_sel = data[3:0] - 4'd1;
		end else if (addr[15:12] == 4'hF) begin
			if (exp_sel < 4'd3) begin
				exp_prg[exp_sel[1:0]][3:0] = data[3:0];
			end else if (exp_sel == 4'd3) begin
				exp_prg[3] = data[4:0];
			end
			if (addr[11:10] == 2'b00 && addr[2:0] < 3'd3) begin
				exp_prg[addr[1:0]][4] = data[4];
			end else if (addr[11:10] == 2'b10) begin
				exp_mirror = data[0];
			end else if (addr[11:10] == 2'b11) begin
				exp_chr[addr[2:0]] = data;
			end
		end
	endtask

	task automatic check_prg_windows(input string name);
		logic [4:0] hi;
		for (int w = 0; w < 4; w++) begin
			@(negedge m2);
			cpu_ce = 1'b0;
			cpu_addr = {1'b1, 2'(w), 13'h0ABC};
			#1;
			hi = (w == 3) ? 5'h1F : exp_prg[w];
			expect_value(name, 32'({hi, 13'h0ABC}), 32'(prg_addr));
		end
		@(negedge m2);
		cpu_ce = 1'b1;
		#1;
		expect_value({name, " cpu_ce"}, 32'({exp_prg[3], 13'h0ABC}), 32'(prg_addr));
		cpu_ce = 1'b0;
	endtask

	task automatic check_chr_windows(input string name);
		for (int s = 0; s < 8; s++) begin
			@(negedge m2);
			ppu_addr = {1'b0, 3'(s), 10'h155};
			#1;
			expect_value(name, 32'({exp_chr[s], 10'h155}), 32'(chr_addr));
		end
	endtask

	task automatic check_mirroring(input string name);
		for (int a = 0; a < 4; a++) begin
			@(negedge m2);
			ppu_addr = {1'b1, 1'b0, 2'(a), 10'h000};
			#1;
			expect_value(name, 32'(exp_mirror ? a[1] : a[0]), 32'(ciram_a10));
		end
	endtask

	task automatic reset_defaults();
		logic [7:0] rd;
		expect_value("reset irq", 32'd0, 32'(irq));
		ss_read(8'd12, rd);
		expect_value("reset flags", 32'd0, 32'(rd));
		check_prg_windows("reset prg");
		check_mirroring("reset mirroring");
	endtask

	task automatic prg_banking();
		int r;
		logic [7:0] data;
		for (int n = 0; n < 4; n++) begin
			r = $random(seed);
			data = r[7:0];
			data[4] = 1'b1;
			write_and_track(16'hE000, 8'(n + 1));
			write_and_track(16'hF000 | 16'(n), data);
			check_prg_windows("prg banking");
		end
		// Pointer past bank 3 leaves only the sub 00 effect on bank 1
		write_and_track(16'hE000, 8'h00);
		write_and_track(16'hF001, 8'h00);
		check_prg_windows("prg bit 4 clear");
	endtask

	task automatic chr_banking();
		int r;
		logic [7:0] data;
		for (int i = 0; i < 8; i++) begin
			r = $random(seed);
			data = r[7:0];
			write_and_track(16'hFC00 | 16'(i), data);
		end
		check_chr_windows("chr banking");
		for (int m = 1; m >= 0; m--) begin
			write_and_track(16'hF800, 8'(m));
			check_mirroring("chr mirroring");
		end
		// ppu_we is an active-low strobe
		for (int c = 0; c < 2; c++) begin
			for (int w = 0; w < 2; w++) begin
				@(negedge m2);
				cfg_chr_ram = 1'(c);
				ppu_we = 1'(w);
				ppu_addr = 14'h0400;
				#1;
				expect_value("chr_we", 32'(c == 1 && w == 0), 32'(chr_we));
			end
		end
		@(negedge m2);
		cfg_chr_ram = 1'b0;
		ppu_we = 1'b1;
	endtask

	task automatic irq_countdown();
		cpu_write(16'h8000, 8'h00);
		cpu_write(16'h9000, 8'h0F);
		cpu_write(16'hA000, 8'h0F);
		cpu_write(16'hB000, 8'h0F);
		cpu_write(16'hC000, 8'h01);
		// Counts FFF0 up to FFFE, and the edge after that raises irq
		for (int i = 1; i <= 15; i++) begin
			@(posedge m2);
			@(negedge m2);
			expect_value("irq countdown", 32'(i == 15), 32'(irq));
		end
		cpu_write(16'hD000, 8'h00);
		expect_value("irq ack", 32'd0, 32'(irq));
		cpu_write(16'hC000, 8'h01);
		cpu_write(16'hC000, 8'h00);
		for (int i = 0; i < 20; i++) begin
			@(posedge m2);
			@(negedge m2);
			expect_value("irq disabled", 32'd0, 32'(irq));
		end
	endtask

	task automatic save_state_roundtrip();
		int r;
		logic [7:0] image [17];
		logic [7:0] rd;
		for (int a = 0; a < 17; a++) begin
			r = $random(seed);
			image[a] = r[7:0];
		end
		// Timer enabled with the flag set, mirror 1 and pointer 2
		image[12] = 8'h72;
		image[13] = 8'h34;
		image[14] = 8'h12;
		image[15] = 8'hCD;
		image[16] = 8'hAB;
		@(negedge m2);
		ss_act = 1'b1;
		for (int a = 0; a < 17; a++) begin
			ss_write(8'(a), image[a]);
		end
		repeat (10) @(posedge m2);
		for (int a = 0; a < 17; a++) begin
			ss_read(8'(a), rd);
			expect_value("save state readback",
				32'((a >= 8 && a < 12) ? {3'b000, image[a][4:0]} : image[a]), 32'(rd));
		end
		for (int a = 0; a < 8; a++) begin
			exp_chr[a] = image[a];
		end
		for (int a = 0; a < 4; a++) begin
			exp_prg[a] = image[a + 8][4:0];
		end
		exp_mirror = 1'b1;
		exp_sel = 4'd2;
		check_prg_windows("save state prg");
		check_chr_windows("save state chr");
		check_mirroring("save state mirroring");
		expect_value("save state irq", 32'd1, 32'(irq));
		ss_read(8'd127, rd);
		expect_value("save state id", 32'h04, 32'(rd));
		ss_read(8'd50, rd);
		expect_value("save state unmapped", 32'hFF, 32'(rd));
		// Counting resumes once the controller lets go
		@(negedge m2);
		ss_act = 1'b0;
		ss_read(8'd13, rd);
		expect_value("save state count resume", 32'h35, 32'(rd));
	endtask

	task automatic chip_enables();
		logic [15:0] addrs [4];
		logic in_ram;
		addrs = '{16'h6000, 16'h7FFF, 16'h8000, 16'h2000};
		for (int i = 0; i < 4; i++) begin
			for (int ce = 0; ce < 2; ce++) begin
				@(negedge m2);
				cpu_addr = addrs[i];
				cpu_ce = 1'(ce);
				#1;
				expect_value("ram_ce m2 low", 32'd0, 32'(ram_ce));
				@(posedge m2);
				#1;
				in_ram = (addrs[i] >= 16'h6000) && (addrs[i] <= 16'h7FFF);
				expect_value("ram_ce", 32'(in_ram && ce == 1), 32'(ram_ce));
				expect_value("rom_ce", 32'(ce == 0), 32'(rom_ce));
			end
		end
		for (int rw = 0; rw < 2; rw++) begin
			@(negedge m2);
			cpu_ce = 1'b0;
			cpu_addr = 16'h6000;
			cpu_rw = 1'(rw);
			#1;
			expect_value("ram_we", 32'(rw == 0), 32'(ram_we));
			expect_value("prg_oe", 32'(rw == 1), 32'(prg_oe));
			cpu_rw = 1'b1;
		end
		for (int oe = 0; oe < 2; oe++) begin
			for (int nt = 0; nt < 2; nt++) begin
				@(negedge m2);
				ppu_oe = 1'(oe);
				ppu_addr = {1'(nt), 13'h0040};
				#1;
				expect_value("chr_oe", 32'(oe == 0), 32'(chr_oe));
				expect_value("ciram_ce", 32'(nt == 0), 32'(ciram_ce));
				// CHR memory is selected for the pattern tables below $2000
				expect_value("chr_ce", 32'(nt == 0), 32'(chr_ce));
			end
		end
	endtask

	initial begin
		m2 = 1'b0;
		map_rst = 1'b1;
		cpu_addr = 16'h0000;
		cpu_dat = 8'h00;
		cpu_rw = 1'b1;
		cpu_ce = 1'b0;
		ppu_addr = 14'h0000;
		ppu_oe = 1'b1;
		ppu_we = 1'b1;
		cfg_chr_ram = 1'b0;
		ss_act = 1'b0;
		ss_we = 1'b0;
		ss_addr = 8'h00;
		error_count = 0;
		check_count = 0;
		seed = 11796;
		for (int i = 0; i < 4; i++) begin
			exp_prg[i] = 5'h00;
		end
		for (int i = 0; i < 8; i++) begin
			exp_chr[i] = 8'h00;
		end
		exp_sel = 4'd0;
		exp_mirror = 1'b0;

		repeat (3) @(posedge m2);
		@(negedge m2);
		map_rst = 1'b0;

		reset_defaults();
		prg_banking();
		chr_banking();
		irq_countdown();
		save_state_roundtrip();
		chip_enables();

		$display("Summary: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog timeout after %0d ns, the tests did not finish", TIMEOUT_NS);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
hw/mapper_pkg.sv
hw/savestate_pkg.sv
hw/map_wr_if.sv
hw/map_reg_decode.sv
hw/bank_regs.sv
hw/irq_timer.sv
hw/savestate_readback.sv
hw/mapper_056_top.sv
testbench/tb_mapper_056.sv

//--- run_sim.sh
#!/bin/sh
# Build the mapper 056 testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_mapper_056 -o sim_mapper_056
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/sim_mapper_056)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "Everything OK"; then
	exit 0
fi

echo "Pass message not found in simulation output"
exit 1
